//--- source/bally_pkg.sv
`default_nettype none

package bally_pkg;

	typedef logic [12:0] cart_addr_t; // 8 KiB cartridge space
	typedef logic [7:0]  cart_byte_t;
	typedef logic [24:0] ioctl_addr_t; // host download address

	// one byte written into the cartridge memory
	typedef struct packed {
		cart_addr_t addr;
		cart_byte_t data;
	} cart_wr_t;

	// published by the loader once an image is in place
	typedef struct packed {
		logic       loaded;
		cart_addr_t addr_mask; // all ones below the top written bit
	} cart_info_t;

	localparam logic [7:0] CART_INDEX = 8'd0; // menu index of a cartridge image
	localparam int         CART_BYTES = 8192;

endpackage

`default_nettype wire

//--- source/ioctl_loader.sv
`timescale 1ns/10ps
`default_nettype none

module ioctl_loader import bally_pkg::*; (
	input  wire logic        clk_14,
	input  wire logic        rst_n,
	input  wire logic        ioctl_download,
	input  wire logic [7:0]  ioctl_index,
	input  wire logic        ioctl_wr,
	input  wire ioctl_addr_t ioctl_addr,
	input  wire cart_byte_t  ioctl_dout,
	input  wire logic        reset_req,
	output cart_wr_t         wr_beat,
	output logic             wr_stb,
	output cart_info_t       info,
	output logic             download_active,
	output logic             load_error,
	output logic             core_reset
);

	logic       download_d;
	logic       dl_rise;
	logic       dl_fall;
	logic       cart_idx;
	logic       in_range;
	logic       accept;
	logic       bad_addr;
	cart_addr_t wr_addr;
	cart_addr_t mask_base;

	// fill every bit below the highest set bit
	function automatic cart_addr_t smear(input cart_addr_t v);
		cart_addr_t s;
		s = v;
		for (int i = $bits(cart_addr_t) - 2; i >= 0; i--) begin
			s[i] = s[i] | s[i + 1];
		end
		return s;
	endfunction

	assign dl_rise = ioctl_download & ~download_d;
	assign dl_fall = ~ioctl_download & download_d;
	assign cart_idx = ioctl_index == CART_INDEX;
	assign in_range = ioctl_addr < ioctl_addr_t'(CART_BYTES);
	assign accept = ioctl_download & ioctl_wr & cart_idx & in_range;
	assign bad_addr = ioctl_download & ioctl_wr & cart_idx & ~in_range;
	assign wr_addr = ioctl_addr[$bits(cart_addr_t) - 1:0];
	assign mask_base = (dl_rise && cart_idx) ? '0 : info.addr_mask; // first beat starts fresh
	assign download_active = ioctl_download;

	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			wr_stb <= 1'b0;
		end else begin
			download_d <= ioctl_download;
			wr_stb <= accept;
		end
	end

	always_ff @(posedge clk_14) begin
		if (accept) begin
			wr_beat <= '{addr: wr_addr, data: ioctl_dout};
		end
	end

	// a download under another index leaves the current image alone
	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			info <= '0;
		end else begin
			if (dl_rise && cart_idx) begin
				info.loaded <= 1'b0;
			end else if (dl_fall && cart_idx) begin
				info.loaded <= 1'b1;
			end
			if (accept) begin
				info.addr_mask <= smear(mask_base | wr_addr);
			end else if (dl_rise && cart_idx) begin
				info.addr_mask <= '0;
			end
		end
	end

	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			load_error <= 1'b0;
		end else if (bad_addr) begin
			load_error <= 1'b1; // sticky until the next download
		end else if (dl_rise) begin
			load_error <= 1'b0;
		end
	end

	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= reset_req | ioctl_download;
		end
	end

	// strobes only come out of an active download
	a_stb_in_download: assert property (@(posedge clk_14) disable iff (!rst_n)
		wr_stb |-> $past(download_active));

endmodule

`default_nettype wire

//--- source/cart_rom.sv
`timescale 1ns/10ps
`default_nettype none

module cart_rom import bally_pkg::*; #(
	parameter int CART_BYTES = bally_pkg::CART_BYTES
) (
	input  wire logic       clk_14,
	input  wire cart_wr_t   wr_beat,
	input  wire logic       wr_stb,
	input  wire cart_addr_t rd_addr,
	input  wire logic       rd_en,
	output cart_byte_t      rd_data
);

	localparam int AW = $clog2(CART_BYTES);

	cart_byte_t mem [CART_BYTES];

	logic [AW - 1:0] wr_idx;
	logic [AW - 1:0] rd_idx;

	assign wr_idx = wr_beat.addr[AW - 1:0]; // smaller memories wrap
	assign rd_idx = rd_addr[AW - 1:0];

	always_ff @(posedge clk_14) begin
		if (wr_stb) begin
			mem[wr_idx] <= wr_beat.data;
		end
	end

	always_ff @(posedge clk_14) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

	// the bus blanks during downloads so the ports never collide
	a_no_rd_wr: assert property (@(posedge clk_14)
		rd_en |-> !wr_stb);

endmodule

`default_nettype wire

//--- source/cart_bus.sv
`timescale 1ns/10ps
`default_nettype none

module cart_bus import bally_pkg::*; (
	input  wire logic       clk_14,
	input  wire logic       rst_n,
	input  wire cart_addr_t cas_addr,
	input  wire logic       cas_cs_l,
	input  wire cart_info_t info,
	input  wire logic       download_active,
	output cart_addr_t      rd_addr,
	output logic            rd_en,
	output cart_byte_t      cas_data,
	input  wire cart_byte_t rd_data
);

	logic       s1_valid;
	logic       s1_blank;
	cart_addr_t s1_addr;
	logic       s2_valid;
	logic       s2_blank;

	// stage 1 mirrors the address and decides on blanking
	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_blank <= 1'b1;
		end else begin
			s1_valid <= ~cas_cs_l;
			s1_blank <= download_active | ~info.loaded;
		end
	end

	always_ff @(posedge clk_14) begin
		s1_addr <= cas_addr & info.addr_mask; // short images repeat
	end

	assign rd_addr = s1_addr;
	assign rd_en = s1_valid & ~s1_blank;

	// stage 2 runs beside the memory read
	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
			s2_blank <= 1'b1;
		end else begin
			s2_valid <= s1_valid;
			s2_blank <= s1_blank;
		end
	end

	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			cas_data <= 8'hFF;
		end else if (s2_valid) begin
			cas_data <= s2_blank ? 8'hFF : rd_data; // open bus while blanked
		end
	end

	// output holds between accesses
	a_hold_data: assert property (@(posedge clk_14) disable iff (!rst_n)
		!s2_valid |=> $stable(cas_data));

endmodule

`default_nettype wire

//--- source/audio_dac.sv
`timescale 1ns/10ps
`default_nettype none

module audio_dac import bally_pkg::*; (
	input  wire logic       clk_14,
	input  wire logic       rst_n,
	input  wire cart_byte_t audio,
	output logic            dac_out
);

	logic [8:0] acc; // bit 8 holds the last carry

	// first order sigma delta whose carries per 256 cycles equal the sample
	always_ff @(posedge clk_14) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[7:0]} + {1'b0, audio};
		end
	end

	assign dac_out = acc[8];

endmodule

`default_nettype wire

//--- source/bally_cart_top.sv
`timescale 1ns/10ps
`default_nettype none

module bally_cart_top import bally_pkg::*; #(
	parameter int CART_BYTES = bally_pkg::CART_BYTES
) (
	input  wire logic        clk_14,
	input  wire logic        rst_n,
	input  wire logic        ioctl_download,
	input  wire logic [7:0]  ioctl_index,
	input  wire logic        ioctl_wr,
	input  wire ioctl_addr_t ioctl_addr,
	input  wire cart_byte_t  ioctl_dout,
	input  wire logic        reset_req,
	input  wire cart_addr_t  cas_addr,
	input  wire logic        cas_cs_l,
	input  wire cart_byte_t  audio,
	output cart_byte_t       cas_data,
	output logic             core_reset,
	output logic             load_error,
	output logic             audio_l,
	output logic             audio_r
);

	cart_wr_t   wr_beat;
	logic       wr_stb;
	cart_info_t info;
	logic       download_active;
	cart_addr_t rd_addr;
	logic       rd_en;
	cart_byte_t rd_data;

	ioctl_loader ioctl_loader_inst (
		.clk_14          (clk_14),
		.rst_n           (rst_n),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_dout      (ioctl_dout),
		.reset_req       (reset_req),
		.wr_beat         (wr_beat),
		.wr_stb          (wr_stb),
		.info            (info),
		.download_active (download_active),
		.load_error      (load_error),
		.core_reset      (core_reset)
	);

	cart_rom #(
		.CART_BYTES (CART_BYTES)
	) cart_rom_inst (
		.clk_14  (clk_14),
		.wr_beat (wr_beat),
		.wr_stb  (wr_stb),
		.rd_addr (rd_addr),
		.rd_en   (rd_en),
		.rd_data (rd_data)
	);

	cart_bus cart_bus_inst (
		.clk_14          (clk_14),
		.rst_n           (rst_n),
		.cas_addr        (cas_addr),
		.cas_cs_l        (cas_cs_l),
		.info            (info),
		.download_active (download_active),
		.rd_addr         (rd_addr),
		.rd_en           (rd_en),
		.cas_data        (cas_data),
		.rd_data         (rd_data)
	);

	// the DAC runs off clk_14 here
	audio_dac audio_dac_inst (
		.clk_14  (clk_14),
		.rst_n   (rst_n),
		.audio   (audio),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l; // mono to both channels

endmodule

`default_nettype wire

//--- verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_total = 0;
int error_total = 0;

task automatic check_byte(input string name, input cart_byte_t got, input cart_byte_t exp);
	check_total++;
	if (got !== exp) begin
		error_total++;
		$display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	check_total++;
	if (got !== exp) begin
		error_total++;
		$display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	check_total++;
	if (got != exp) begin
		error_total++;
		$display("FAIL t=%0t %s got %0d exp %0d", $time, name, got, exp);
	end
endtask

// xorshift32 with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

`endif

//--- verification/tb_bally_cart.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bally_cart import bally_pkg::*; ();

	localparam int WAIT_LIMIT = 32; // cycles before a wait gives up

	logic        clk_14;
	logic        rst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	cart_byte_t  ioctl_dout;
	logic        reset_req;
	cart_addr_t  cas_addr;
	logic        cas_cs_l;
	cart_byte_t  audio;
	cart_byte_t  cas_data;
	logic        core_reset;
	logic        load_error;
	logic        audio_l;
	logic        audio_r;

	cart_byte_t  model_mem [CART_BYTES]; // expected image contents
	cart_addr_t  model_mask;
	logic        model_loaded;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic [31:0] rng = 32'h69be5deb;
	cart_addr_t  read_addrs [$];
	cart_byte_t  read_exps [$];
	logic        aborted;
	string       test_name;
	int          err_mark;
	int          chk_mark;

	`include "tb_checks.svh"

	bally_cart_top #(.CART_BYTES(CART_BYTES)) bally_cart_top_inst (
		.clk_14(clk_14), .rst_n(rst_n), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .reset_req(reset_req), .cas_addr(cas_addr),
		.cas_cs_l(cas_cs_l), .audio(audio), .cas_data(cas_data), .core_reset(core_reset),
		.load_error(load_error), .audio_l(audio_l), .audio_r(audio_r)
	);

	initial begin
		clk_14 = 1'b0;
		forever #4 clk_14 = ~clk_14;
	end

	task automatic tick();
		@(posedge clk_14);
		#1; // inputs change just after the edge
	endtask

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// ones from the top set bit of everything written so far downward
	function automatic cart_addr_t span_mask(input cart_addr_t m, input cart_addr_t a);
		cart_addr_t v;
		cart_addr_t r;
		v = m | a;
		r = '0;
		for (int b = 0; b < $bits(cart_addr_t); b++) begin
			if (v[b]) r = cart_addr_t'((1 << (b + 1)) - 1);
		end
		return r;
	endfunction

	function automatic cart_byte_t expected_read(input cart_addr_t a);
		if (dl_active || !model_loaded) begin
			return 8'hFF; // blanked bus
		end
		return model_mem[a & model_mask];
	endfunction

	task automatic wait_reset_release(output int cycles);
		cycles = 0;
		while (core_reset !== 1'b0 && cycles < WAIT_LIMIT) begin
			tick();
			cycles++;
		end
		if (core_reset !== 1'b0) begin
			$display("timeout at %0t: core_reset stayed high after its sources went low", $time);
			error_total++;
			aborted = 1'b1;
		end
	endtask

	// core_reset follows reset_req | download one cycle later
	task automatic settle_core_reset();
		int cycles;
		if (reset_req || ioctl_download) begin
			tick();
			check_flag("core_reset", core_reset, 1'b1);
		end else begin
			wait_reset_release(cycles);
			if (!aborted) check_count("core_reset latency", cycles, 1);
		end
	endtask

	task automatic begin_download(input logic [7:0] idx);
		ioctl_download = 1'b1;
		ioctl_index = idx;
		dl_active = 1'b1;
		dl_index = idx;
		if (idx == CART_INDEX) begin
			model_loaded = 1'b0;
			model_mask = '0;
		end
		settle_core_reset();
	endtask

	task automatic finish_download();
		ioctl_download = 1'b0;
		dl_active = 1'b0;
		if (dl_index == CART_INDEX) model_loaded = 1'b1;
		settle_core_reset();
	endtask

	task automatic write_byte(input logic [31:0] addr, input cart_byte_t data);
		ioctl_wr = 1'b1;
		ioctl_addr = ioctl_addr_t'(addr);
		ioctl_dout = data;
		if (dl_active && dl_index == CART_INDEX && addr < CART_BYTES) begin
			model_mem[addr[12:0]] = data;
			model_mask = span_mask(model_mask, addr[12:0]);
		end
		tick();
	endtask

	// one read per cycle and each checked three edges after it was driven
	task automatic run_reads();
		int n;
		n = read_addrs.size();
		for (int k = 0; k < n + 3; k++) begin
			if (k >= 3) begin
				check_byte($sformatf("cas_data at %h", read_addrs[k - 3]), cas_data,
					read_exps[k - 3]);
			end
			cas_cs_l = (k >= n);
			if (k < n) cas_addr = read_addrs[k];
			tick();
		end
		read_addrs.delete();
		read_exps.delete();
	endtask

	task automatic check_audio(input cart_byte_t v, input int exp_ones);
		int ones;
		int skew;
		ones = 0;
		skew = 0;
		audio = v;
		tick();
		for (int i = 0; i < 256; i++) begin
			if (audio_l) ones++;
			if (audio_r !== audio_l) skew++;
			tick();
		end
		check_count("audio_l ones", ones, exp_ones);
		check_count("audio_r mismatches", skew, 0);
	endtask

	task automatic close_test();
		if (test_name != "") begin
			$display("test %s: %0d errors in %0d checks", test_name, error_total - err_mark,
				check_total - chk_mark);
		end
		err_mark = error_total;
		chk_mark = check_total;
	endtask

	task automatic end_run();
		close_test();
		$display("%0d checks, %0d errors", check_total, error_total);
		if (error_total == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		int           fd;
		int           code;
		int           ch;
		int           cycles;
		logic [255:0] tok;
		string        cmd;
		logic [31:0]  v1;
		logic [31:0]  v2;
		logic [31:0]  r;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		reset_req = 1'b0;
		cas_addr = '0;
		cas_cs_l = 1'b1;
		audio = '0;
		model_mask = '0;
		model_loaded = 1'b0;
		dl_active = 1'b0;
		dl_index = '0;
		aborted = 1'b0;
		test_name = "";
		err_mark = 0;
		chk_mark = 0;
		repeat (3) @(posedge clk_14);
		#1 rst_n = 1'b1;
		wait_reset_release(cycles);
		fd = $fopen("verification/cart_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/cart_stim.txt");
			error_total++;
			aborted = 1'b1;
		end
		while (!aborted) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;
			cmd = string'(tok);
			if (cmd == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (cmd == "T") begin
				code = $fscanf(fd, "%s", tok);
				close_test();
				test_name = string'(tok);
			end else if (cmd == "B") begin
				code = $fscanf(fd, "%h", v1);
				begin_download(v1[7:0]);
			end else if (cmd == "F") begin
				finish_download();
			end else if (cmd == "W") begin
				code = $fscanf(fd, "%h %h", v1, v2);
				write_byte(v1, v2[7:0]);
				ioctl_wr = 1'b0;
			end else if (cmd == "W*") begin
				code = $fscanf(fd, "%h %h", v1, v2);
				for (int i = 0; i < int'(v2); i++) begin
					r = next_rand();
					write_byte(v1 + 32'(i), r[7:0]); // back-to-back beats
				end
				ioctl_wr = 1'b0;
			end else if (cmd == "R") begin
				code = $fscanf(fd, "%h %h", v1, v2);
				read_addrs.push_back(v1[12:0]);
				read_exps.push_back(v2[7:0]);
				run_reads();
			end else if (cmd == "R*") begin
				code = $fscanf(fd, "%h", v1);
				read_addrs.push_back(v1[12:0]);
				read_exps.push_back(expected_read(v1[12:0]));
				run_reads();
			end else if (cmd == "N") begin
				code = $fscanf(fd, "%h", v1);
				for (int i = 0; i < int'(v1); i++) begin
					r = next_rand();
					read_addrs.push_back(r[12:0]);
					read_exps.push_back(expected_read(r[12:0]));
				end
				run_reads();
			end else if (cmd == "A") begin
				code = $fscanf(fd, "%h %h", v1, v2);
				check_audio(v1[7:0], int'(v2));
			end else if (cmd == "X") begin
				code = $fscanf(fd, "%h", v1);
				check_flag("load_error", load_error, v1[0]);
			end else if (cmd == "Q") begin
				code = $fscanf(fd, "%h", v1);
				reset_req = v1[0];
				settle_core_reset();
			end else begin
				$display("unknown command %s in the stim file", cmd);
				error_total++;
			end
		end
		if (fd != 0) $fclose(fd);
		end_run();
	end

endmodule

`default_nettype wire

//--- verification/cart_stim.txt
# command and hex arguments: T name, B index, W addr data, W* addr count, F, R addr expected,
# R* addr, N reads, A sample ones, X load_error, Q reset_req
T blank_before_load
R 0000 ff
R 1abc ff
T load_4k
B 00
R 0040 ff
W* 0000 1000
F
N 30
T mirror_2k
B 00
W* 0000 0800
F
R* 0123
R* 0923
T reset_hold
Q 1
B 00
R 0123 ff
W* 0000 0800
F
R* 0123
Q 0
T index_filter
B 01
W 0123 aa
W 07ff 5a
F
R* 0123
R* 07ff
X 0
T range_error
B 00
W* 0000 0800
W 2000 55
X 1
F
X 1
B 00
X 0
W* 0000 0800
F
R* 0456
T audio_dac
A 00 00
A 01 01
A 80 80
A ff ff

//--- flist.f
+incdir+verification
source/bally_pkg.sv
source/ioctl_loader.sv
source/cart_rom.sv
source/cart_bus.sv
source/audio_dac.sv
source/bally_cart_top.sv
verification/tb_bally_cart.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_bally_cart -f flist.f
out=$(./obj_dir/Vtb_bally_cart)
echo "$out"
grep -qx "TESTS PASSED" <<< "$out"
